//--- include/cpu_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu sizing: datapath width, register file, pipeline depth, multiplier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define DATA_W      32  // datapath width
`define REG_ADDR_W  5   // register index width
`define NUM_REGS    32  // architectural registers

// stages between execute and the register file write
`define FWD_STAGES  3

`define MUL_CYCLES  32  // one shift-add step per multiplier bit

`endif

//--- verilog/isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction set encodings for the supported MIPS integer subset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isa_pkg;

    // major opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'h00,
        OP_ADDIU    = 6'h09,
        OP_LUI      = 6'h0f,
        OP_SPECIAL2 = 6'h1c
    } opcode_e;

    // function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_MUL  = 6'h02,    // only valid under SPECIAL2
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    // internal ALU select
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,     // signed compare
        ALU_LUI = 3'd6      // immediate into upper half
    } alu_op_e;

endpackage

//--- verilog/pipe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath types shared by the issue, stage and retire logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_macros.svh"

package pipe_pkg;

    typedef logic [`DATA_W-1:0]     data_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // where an operand comes from
    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_S0 = 2'd1,   // youngest result
        FWD_S1 = 2'd2,
        FWD_S2 = 2'd3    // about to retire
    } fwd_src_e;

endpackage

//--- verilog/issue_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue: decode, forwarded operand read, ALU and shift-add multiplier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_macros.svh"

module issue_unit (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  pipe_pkg::data_t        instr,
    input  pipe_pkg::data_t        pc,
    input  logic [`FWD_STAGES-1:0] stage_rs_hit,
    input  logic [`FWD_STAGES-1:0] stage_rt_hit,
    input  pipe_pkg::data_t        stage_result [`FWD_STAGES],
    input  pipe_pkg::data_t        rf_rs_data,
    input  pipe_pkg::data_t        rf_rt_data,
    output logic                   instr_ready,
    output pipe_pkg::reg_addr_t    rs_addr,
    output pipe_pkg::reg_addr_t    rt_addr,
    output logic                   ex_valid,
    output pipe_pkg::data_t        ex_pc,
    output pipe_pkg::reg_addr_t    ex_dst,
    output pipe_pkg::data_t        ex_result
);

    localparam int CNT_W = $clog2(`MUL_CYCLES);

    isa_pkg::opcode_e    opcode;
    isa_pkg::funct_e     funct;
    isa_pkg::alu_op_e    alu_op;
    logic                is_alu;
    logic                is_mul;
    logic                use_imm;
    logic                fire;
    pipe_pkg::reg_addr_t dst;
    pipe_pkg::fwd_src_e  rs_src;
    pipe_pkg::fwd_src_e  rt_src;
    pipe_pkg::data_t     rs_val;
    pipe_pkg::data_t     rt_val;
    pipe_pkg::data_t     op_b;
    pipe_pkg::data_t     alu_result;

    logic                mul_busy;
    logic                mul_done;
    logic [CNT_W-1:0]    mul_cnt;
    pipe_pkg::data_t     mul_mcand;
    pipe_pkg::data_t     mul_mplier;
    pipe_pkg::data_t     mul_acc;
    pipe_pkg::data_t     mul_step;
    pipe_pkg::reg_addr_t mul_dst;
    pipe_pkg::data_t     mul_pc;

    // first hit wins, stage 0 holds the youngest result
    function automatic pipe_pkg::fwd_src_e pick_src(input logic [`FWD_STAGES-1:0] hit);
        if (hit[0]) return pipe_pkg::FWD_S0;
        if (hit[1]) return pipe_pkg::FWD_S1;
        if (hit[2]) return pipe_pkg::FWD_S2;
        return pipe_pkg::FWD_RF;
    endfunction

    function automatic pipe_pkg::data_t fwd_mux(input pipe_pkg::fwd_src_e src,
                                                input pipe_pkg::data_t res [`FWD_STAGES],
                                                input pipe_pkg::data_t rf_data);
        case (src)
            pipe_pkg::FWD_S0: return res[0];
            pipe_pkg::FWD_S1: return res[1];
            pipe_pkg::FWD_S2: return res[2];
            default:          return rf_data;
        endcase
    endfunction

    assign opcode      = isa_pkg::opcode_e'(instr[31:26]);
    assign funct       = isa_pkg::funct_e'(instr[5:0]);
    assign rs_addr     = instr[25:21];
    assign rt_addr     = instr[20:16];
    assign instr_ready = !mul_busy;  // only the multiplier stalls issue
    assign fire        = instr_valid && instr_ready;

    always_comb begin
        is_alu  = 1'b0;
        is_mul  = 1'b0;
        use_imm = 1'b0;
        alu_op  = isa_pkg::ALU_ADD;
        dst     = instr[15:11];      // rd for R format
        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                is_alu = 1'b1;
                case (funct)
                    isa_pkg::FN_ADDU: alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_SLT:  alu_op = isa_pkg::ALU_SLT;
                    default:          is_alu = 1'b0;  // retires as a nop
                endcase
            end
            isa_pkg::OP_SPECIAL2: is_mul = (funct == isa_pkg::FN_MUL);
            isa_pkg::OP_ADDIU: begin
                is_alu  = 1'b1;
                use_imm = 1'b1;
                dst     = instr[20:16];
            end
            isa_pkg::OP_LUI: begin
                is_alu  = 1'b1;
                use_imm = 1'b1;
                alu_op  = isa_pkg::ALU_LUI;
                dst     = instr[20:16];
            end
            default: ;
        endcase
    end

    assign rs_src = pick_src(stage_rs_hit);
    assign rt_src = pick_src(stage_rt_hit);
    assign rs_val = fwd_mux(rs_src, stage_result, rf_rs_data);
    assign rt_val = fwd_mux(rt_src, stage_result, rf_rt_data);
    assign op_b   = use_imm ? {{(`DATA_W-16){instr[15]}}, instr[15:0]} : rt_val;

    always_comb begin
        case (alu_op)
            isa_pkg::ALU_SUB: alu_result = rs_val - op_b;
            isa_pkg::ALU_AND: alu_result = rs_val & op_b;
            isa_pkg::ALU_OR:  alu_result = rs_val | op_b;
            isa_pkg::ALU_XOR: alu_result = rs_val ^ op_b;
            isa_pkg::ALU_SLT: alu_result = {{(`DATA_W-1){1'b0}}, $signed(rs_val) < $signed(op_b)};
            isa_pkg::ALU_LUI: alu_result = {instr[15:0], 16'h0000};
            default:          alu_result = rs_val + op_b;
        endcase
    end

    // last step is folded into the output, so the product is ready in the final cycle
    assign mul_step = mul_acc + (mul_mplier[0] ? mul_mcand : '0);
    assign mul_done = mul_busy && (mul_cnt == CNT_W'(`MUL_CYCLES - 1));

    always_ff @(posedge aclk) begin
        if (reset) begin
            mul_busy <= 1'b0;
            mul_cnt  <= '0;
        end else if (fire && is_mul) begin
            mul_busy <= 1'b1;
            mul_cnt  <= '0;
        end else if (mul_done) begin
            mul_busy <= 1'b0;
        end else if (mul_busy) begin
            mul_cnt  <= mul_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (fire && is_mul) begin
            mul_mcand  <= rs_val;       // operands already forwarded
            mul_mplier <= rt_val;
            mul_acc    <= '0;
            mul_dst    <= dst;
            mul_pc     <= pc;
        end else if (mul_busy) begin
            mul_acc    <= mul_step;
            mul_mcand  <= mul_mcand << 1;
            mul_mplier <= mul_mplier >> 1;
        end
    end

    assign ex_valid  = (fire && is_alu) || mul_done;
    assign ex_pc     = mul_done ? mul_pc : pc;
    assign ex_dst    = mul_done ? mul_dst : dst;
    assign ex_result = mul_done ? mul_step : alu_result;

endmodule

//--- verilog/pipe_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// post-execute stage register with its own forwarding match
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pipe_stage (
    input  logic                aclk,
    input  logic                reset,
    input  logic                in_valid,
    input  pipe_pkg::data_t     in_pc,
    input  pipe_pkg::reg_addr_t in_dst,
    input  pipe_pkg::data_t     in_result,
    input  pipe_pkg::reg_addr_t rs_addr,
    input  pipe_pkg::reg_addr_t rt_addr,
    output logic                out_valid,
    output pipe_pkg::data_t     out_pc,
    output pipe_pkg::reg_addr_t out_dst,
    output pipe_pkg::data_t     out_result,
    output logic                rs_hit,
    output logic                rt_hit
);

    always_ff @(posedge aclk) begin
        if (reset) out_valid <= 1'b0;
        else       out_valid <= in_valid;  // never stalls
    end

    always_ff @(posedge aclk) begin
        out_pc     <= in_pc;
        out_dst    <= in_dst;
        out_result <= in_result;
    end

    // r0 never forwards, it always reads as zero
    assign rs_hit = out_valid && (out_dst != '0) && (out_dst == rs_addr);
    assign rt_hit = out_valid && (out_dst != '0) && (out_dst == rt_addr);

endmodule

//--- verilog/retire_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file write at retirement and the golden-trace debug port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_macros.svh"

module retire_unit (
    input  logic                aclk,
    input  logic                reset,
    input  logic                ret_valid,
    input  pipe_pkg::data_t     ret_pc,
    input  pipe_pkg::reg_addr_t ret_dst,
    input  pipe_pkg::data_t     ret_result,
    input  pipe_pkg::reg_addr_t rs_addr,
    input  pipe_pkg::reg_addr_t rt_addr,
    output pipe_pkg::data_t     rs_data,
    output pipe_pkg::data_t     rt_data,
    output pipe_pkg::data_t     debug_wb_pc,
    output pipe_pkg::data_t     debug_wb_rf_wdata,
    output logic [3:0]          debug_wb_rf_wen,
    output pipe_pkg::reg_addr_t debug_wb_rf_wnum
);

    pipe_pkg::data_t regs [`NUM_REGS];
    logic            rf_we;

    assign rf_we = ret_valid && (ret_dst != '0);  // writes to r0 are dropped

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[ret_dst] <= ret_result;
        end
    end

    // async read, r0 hardwired to zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    assign debug_wb_pc       = ret_pc;
    assign debug_wb_rf_wdata = ret_result;
    assign debug_wb_rf_wen   = rf_we ? 4'b1111 : 4'b0000;  // full word or nothing
    assign debug_wb_rf_wnum  = ret_dst;

endmodule

//--- verilog/mips_pipe_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order integer pipeline: issue, forwarding stages, retire
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_macros.svh"

module mips_pipe_top (
    input  logic                aclk,
    input  logic                reset,
    input  logic                instr_valid,
    input  pipe_pkg::data_t     instr,
    input  pipe_pkg::data_t     pc,
    output logic                instr_ready,
    output pipe_pkg::data_t     debug_wb_pc,
    output pipe_pkg::data_t     debug_wb_rf_wdata,
    output logic [3:0]          debug_wb_rf_wen,
    output pipe_pkg::reg_addr_t debug_wb_rf_wnum
);

    pipe_pkg::reg_addr_t    rs_addr;           // from issue, to stages and regfile
    pipe_pkg::reg_addr_t    rt_addr;
    pipe_pkg::data_t        rf_rs_data;
    pipe_pkg::data_t        rf_rt_data;
    logic                   ex_valid;          // execute result into stage 0
    pipe_pkg::data_t        ex_pc;
    pipe_pkg::reg_addr_t    ex_dst;
    pipe_pkg::data_t        ex_result;

    logic                   st_valid  [`FWD_STAGES];
    pipe_pkg::data_t        st_pc     [`FWD_STAGES];
    pipe_pkg::reg_addr_t    st_dst    [`FWD_STAGES];
    pipe_pkg::data_t        st_result [`FWD_STAGES];  // also the forwarding values
    logic [`FWD_STAGES-1:0] st_rs_hit;
    logic [`FWD_STAGES-1:0] st_rt_hit;

    issue_unit u_issue_unit (
        .aclk               (aclk),
        .reset              (reset),
        .instr_valid        (instr_valid),
        .instr              (instr),
        .pc                 (pc),
        .stage_rs_hit       (st_rs_hit),
        .stage_rt_hit       (st_rt_hit),
        .stage_result       (st_result),
        .rf_rs_data         (rf_rs_data),
        .rf_rt_data         (rf_rt_data),
        .instr_ready        (instr_ready),
        .rs_addr            (rs_addr),
        .rt_addr            (rt_addr),
        .ex_valid           (ex_valid),
        .ex_pc              (ex_pc),
        .ex_dst             (ex_dst),
        .ex_result          (ex_result)
    );

    for (genvar i = 0; i < `FWD_STAGES; i++) begin : g_stage
        if (i == 0) begin : g_first
            pipe_stage u_pipe_stage (
                .aclk       (aclk),
                .reset      (reset),
                .in_valid   (ex_valid),
                .in_pc      (ex_pc),
                .in_dst     (ex_dst),
                .in_result  (ex_result),
                .rs_addr    (rs_addr),
                .rt_addr    (rt_addr),
                .out_valid  (st_valid[i]),
                .out_pc     (st_pc[i]),
                .out_dst    (st_dst[i]),
                .out_result (st_result[i]),
                .rs_hit     (st_rs_hit[i]),
                .rt_hit     (st_rt_hit[i])
            );
        end else begin : g_next
            pipe_stage u_pipe_stage (
                .aclk       (aclk),
                .reset      (reset),
                .in_valid   (st_valid[i-1]),
                .in_pc      (st_pc[i-1]),
                .in_dst     (st_dst[i-1]),
                .in_result  (st_result[i-1]),
                .rs_addr    (rs_addr),
                .rt_addr    (rt_addr),
                .out_valid  (st_valid[i]),
                .out_pc     (st_pc[i]),
                .out_dst    (st_dst[i]),
                .out_result (st_result[i]),
                .rs_hit     (st_rs_hit[i]),
                .rt_hit     (st_rt_hit[i])
            );
        end
    end

    retire_unit u_retire_unit (
        .aclk               (aclk),
        .reset              (reset),
        .ret_valid          (st_valid[`FWD_STAGES-1]),
        .ret_pc             (st_pc[`FWD_STAGES-1]),
        .ret_dst            (st_dst[`FWD_STAGES-1]),
        .ret_result         (st_result[`FWD_STAGES-1]),
        .rs_addr            (rs_addr),
        .rt_addr            (rt_addr),
        .rs_data            (rf_rs_data),
        .rt_data            (rf_rt_data),
        .debug_wb_pc        (debug_wb_pc),
        .debug_wb_rf_wdata  (debug_wb_rf_wdata),
        .debug_wb_rf_wen    (debug_wb_rf_wen),
        .debug_wb_rf_wnum   (debug_wb_rf_wnum)
    );

endmodule

//--- verification/mips_pipe_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace and handshake assertions bound into the pipeline top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_macros.svh"

module mips_pipe_checker (
    input logic                aclk,
    input logic                reset,
    input logic                instr_valid,
    input pipe_pkg::data_t     instr,
    input logic                instr_ready,
    input logic [3:0]          debug_wb_rf_wen,
    input pipe_pkg::reg_addr_t debug_wb_rf_wnum
);

    logic       mul_fire;
    logic [7:0] stall_left;  // stall cycles still owed to a multiply

    assign mul_fire = instr_valid && instr_ready
                   && (instr[31:26] == isa_pkg::OP_SPECIAL2)
                   && (instr[5:0] == isa_pkg::FN_MUL);

    always_ff @(posedge aclk) begin
        if (reset) begin
            stall_left <= 8'd0;
        end else if (mul_fire) begin
            stall_left <= 8'(`MUL_CYCLES - 1);
        end else if (stall_left != 8'd0) begin
            stall_left <= stall_left - 8'd1;
        end
    end

    wen_shape: assert property (@(posedge aclk) disable iff (reset)
        (debug_wb_rf_wen == 4'b0000) || (debug_wb_rf_wen == 4'b1111))
        else $error("write enable is neither a full word nor zero");

    wnum_nonzero: assert property (@(posedge aclk) disable iff (reset)
        (debug_wb_rf_wen != 4'b0000) |-> (debug_wb_rf_wnum != '0))
        else $error("trace write to register 0");

    ready_after_reset: assert property (@(posedge aclk)
        ($past(reset) && !reset) |-> instr_ready)
        else $error("instr_ready low right after reset");

    mul_stall: assert property (@(posedge aclk) disable iff (reset)
        (stall_left != 8'd0) |-> !instr_ready)
        else $error("instr_ready high while the multiply is running");

endmodule

bind mips_pipe_top mips_pipe_checker u_mips_pipe_checker (
    .aclk             (aclk),
    .reset            (reset),
    .instr_valid      (instr_valid),
    .instr            (instr),
    .instr_ready      (instr_ready),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

//--- verification/mips_pipe_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the in-order pipeline, model-checked golden trace
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_macros.svh"

module mips_pipe_tb;

    logic                aclk;
    logic                reset;
    logic                instr_valid;
    pipe_pkg::data_t     instr;
    pipe_pkg::data_t     pc;
    logic                instr_ready;
    pipe_pkg::data_t     debug_wb_pc;
    pipe_pkg::data_t     debug_wb_rf_wdata;
    logic [3:0]          debug_wb_rf_wen;
    pipe_pkg::reg_addr_t debug_wb_rf_wnum;

    pipe_pkg::data_t     model_regs [`NUM_REGS];  // architectural state seen by the model
    pipe_pkg::data_t     exp_pc [$];
    pipe_pkg::reg_addr_t exp_num [$];
    pipe_pkg::data_t     exp_data [$];
    pipe_pkg::data_t     next_pc;
    string               test_name;
    integer              seed;
    logic                fail_seen;
    logic                run_passed;

    mips_pipe_top mips_pipe_top_inst (
        .aclk              (aclk),
        .reset             (reset),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .pc                (pc),
        .instr_ready       (instr_ready),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #5 aclk = ~aclk;

    task automatic abort_run(input string why);
        $display("%s", why);
        fail_seen = 1'b1;
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input pipe_pkg::data_t expected,
                               input pipe_pkg::data_t actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
            fail_seen = 1'b1;
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic pipe_pkg::data_t r_format(input logic [5:0] op, input logic [5:0] fn,
                                                 input int rd, input int rs, input int rt);
        return {op, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic pipe_pkg::data_t i_format(input logic [5:0] op, input int rt,
                                                 input int rs, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // instruction rules applied in program order at acceptance
    function automatic void model_step(input pipe_pkg::data_t word, input pipe_pkg::data_t at_pc);
        logic [5:0]          op;
        logic [5:0]          fn;
        pipe_pkg::data_t     a;
        pipe_pkg::data_t     b;
        pipe_pkg::data_t     res;
        pipe_pkg::reg_addr_t dst;
        logic                writes;
        op     = word[31:26];
        fn     = word[5:0];
        a      = model_regs[word[25:21]];
        b      = model_regs[word[20:16]];
        dst    = word[15:11];
        writes = 1'b1;
        res    = '0;
        case (op)
            isa_pkg::OP_SPECIAL: begin
                case (fn)
                    isa_pkg::FN_ADDU: res = a + b;
                    isa_pkg::FN_SUBU: res = a - b;
                    isa_pkg::FN_AND:  res = a & b;
                    isa_pkg::FN_OR:   res = a | b;
                    isa_pkg::FN_XOR:  res = a ^ b;
                    isa_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:          writes = 1'b0;
                endcase
            end
            isa_pkg::OP_SPECIAL2: begin
                writes = (fn == isa_pkg::FN_MUL);
                res    = a * b;  // low word only
            end
            isa_pkg::OP_ADDIU: begin
                res = a + {{16{word[15]}}, word[15:0]};
                dst = word[20:16];
            end
            isa_pkg::OP_LUI: begin
                res = {word[15:0], 16'h0000};
                dst = word[20:16];
            end
            default: writes = 1'b0;
        endcase
        if (writes && dst != '0) begin  // r0 writes leave no trace
            model_regs[dst] = res;
            exp_pc.push_back(at_pc);
            exp_num.push_back(dst);
            exp_data.push_back(res);
        end
    endfunction

    // trace sampled mid-cycle
    always @(negedge aclk) begin
        if (!reset && debug_wb_rf_wen != 4'b0000) begin
            if (exp_pc.size() == 0) begin
                abort_run($sformatf("unexpected retirement at pc %h", debug_wb_pc));
            end else begin
                check_value("trace pc", exp_pc.pop_front(), debug_wb_pc);
                check_value("trace wnum", 32'(exp_num.pop_front()), 32'(debug_wb_rf_wnum));
                check_value("trace wdata", exp_data.pop_front(), debug_wb_rf_wdata);
                check_value("trace wen", 32'hf, 32'(debug_wb_rf_wen));
            end
        end
    end

    task automatic issue_instr(input pipe_pkg::data_t word);
        int waited;
        waited      = 0;
        instr_valid = 1'b1;
        instr       = word;
        pc          = next_pc;
        while (!instr_ready) begin  // held while the multiplier is busy
            @(posedge aclk);
            #1;
            waited++;
            if (waited > 4 * `MUL_CYCLES) abort_run("timed out waiting for instr_ready");
        end
        @(posedge aclk);
        #1;
        model_step(word, next_pc);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic drain_pipe();
        int waited;
        waited      = 0;
        instr_valid = 1'b0;
        while (exp_pc.size() != 0) begin
            @(posedge aclk);
            #1;
            waited++;
            if (waited > 8 * `MUL_CYCLES) abort_run("timed out waiting for retirements");
        end
    endtask

    task automatic reset_state();
        test_name = "reset_state";
        check_value("instr_ready", 32'd1, 32'(instr_ready));
        check_value("wen", 32'd0, 32'(debug_wb_rf_wen));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_OR, 3, 1, 2));
        drain_pipe();
    endtask

    task automatic independent_alu();
        test_name = "independent_alu";
        issue_instr(i_format(isa_pkg::OP_LUI, 10, 0, 16'h8000));
        issue_instr(i_format(isa_pkg::OP_ADDIU, 10, 10, 16'h1234));
        issue_instr(i_format(isa_pkg::OP_ADDIU, 11, 0, 16'hfff0));  // -16
        drain_pipe();
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_ADDU, 12, 10, 11));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_SUBU, 13, 10, 11));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_AND, 14, 10, 11));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_OR, 15, 10, 11));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_XOR, 16, 10, 11));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLT, 17, 10, 11));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLT, 18, 11, 10));
        issue_instr(i_format(isa_pkg::OP_ADDIU, 19, 11, 16'h0020));
        issue_instr(i_format(isa_pkg::OP_LUI, 20, 0, 16'hbeef));
        drain_pipe();
    endtask

    task automatic forwarding_chain();
        test_name = "forwarding_chain";
        issue_instr(i_format(isa_pkg::OP_ADDIU, 1, 0, 16'h0007));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_ADDU, 2, 1, 1));  // distance 1
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_XOR, 3, 1, 2));   // distance 2
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_OR, 4, 1, 3));    // distance 3
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_SUBU, 5, 1, 4));  // distance 4
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLT, 6, 5, 2));
        // two copies of r1 in flight, the younger must win
        issue_instr(i_format(isa_pkg::OP_ADDIU, 1, 0, 16'h0064));
        issue_instr(i_format(isa_pkg::OP_ADDIU, 1, 1, 16'h0001));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_ADDU, 7, 1, 1));
        drain_pipe();
    endtask

    task automatic multiply_stall();
        test_name = "multiply_stall";
        issue_instr(i_format(isa_pkg::OP_ADDIU, 1, 0, 16'hfffd));
        issue_instr(i_format(isa_pkg::OP_LUI, 2, 0, 16'h0001));
        issue_instr(r_format(isa_pkg::OP_SPECIAL2, isa_pkg::FN_MUL, 3, 1, 2));
        check_value("instr_ready during mul", 32'd0, 32'(instr_ready));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_ADDU, 4, 3, 1));  // needs product
        drain_pipe();
    endtask

    task automatic silent_writes();
        test_name = "silent_writes";
        issue_instr(i_format(isa_pkg::OP_ADDIU, 0, 0, 16'h0055));
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_OR, 0, 1, 2));
        issue_instr({6'h3f, 26'h0000123});                         // unknown major opcode
        issue_instr(r_format(isa_pkg::OP_SPECIAL, 6'h00, 5, 1, 2));  // shift, not supported
        issue_instr(r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_ADDU, 5, 0, 0));
        drain_pipe();
    endtask

    task automatic random_sequence();
        pipe_pkg::data_t pick;
        pipe_pkg::data_t kind;
        pipe_pkg::data_t word;
        test_name = "random_sequence";
        for (int n = 0; n < 200; n++) begin
            pick = $random(seed);
            kind = $random(seed);
            case (kind[7:0] % 8'd9)  // registers 0..7 keep the hazards dense
                8'd0: word = r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_ADDU,
                                      pick[2:0], pick[5:3], pick[8:6]);
                8'd1: word = r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_SUBU,
                                      pick[2:0], pick[5:3], pick[8:6]);
                8'd2: word = r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_AND,
                                      pick[2:0], pick[5:3], pick[8:6]);
                8'd3: word = r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_OR,
                                      pick[2:0], pick[5:3], pick[8:6]);
                8'd4: word = r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_XOR,
                                      pick[2:0], pick[5:3], pick[8:6]);
                8'd5: word = r_format(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLT,
                                      pick[2:0], pick[5:3], pick[8:6]);
                8'd6: word = i_format(isa_pkg::OP_ADDIU, pick[2:0], pick[5:3], pick[31:16]);
                8'd7: word = i_format(isa_pkg::OP_LUI, pick[2:0], 0, pick[31:16]);
                default: word = r_format(isa_pkg::OP_SPECIAL2, isa_pkg::FN_MUL,
                                         pick[2:0], pick[5:3], pick[8:6]);
            endcase
            issue_instr(word);
        end
        drain_pipe();
    endtask

    initial begin
        seed        = 29;
        fail_seen   = 1'b0;
        run_passed  = 1'b0;
        aclk        = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        next_pc     = 32'hbfc0_0000;
        test_name   = "reset";
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge aclk);
        #1;
        reset = 1'b0;
        reset_state();
        independent_alu();
        forwarding_chain();
        multiply_stall();
        silent_writes();
        random_sequence();
        for (int i = 0; i < 2 * `FWD_STAGES; i++) begin
            @(posedge aclk);  // room for a stray late retirement
        end
        run_passed = 1'b1;
        $display("Test completed successfully");
        $finish;
    end

    final begin
        if (!run_passed && !fail_seen) begin
            $display("Test failed");
        end
    end

endmodule

//--- flist.f
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/issue_unit.sv
verilog/pipe_stage.sv
verilog/retire_unit.sv
verilog/mips_pipe_top.sv
verification/mips_pipe_checker.sv
verification/mips_pipe_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mips_pipe_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
